// ==== verilog/stream_cfg_pkg.sv ====
/*
 * Stream subsystem sizing
 * Port count, payload width and status counter width shared by
 * the dispatcher datapath and its output slices
 */

package stream_cfg_pkg;

  // Number of output streams served by the dispatcher
  localparam int unsigned N_PORTS = 4;

  // Payload word carried with every request
  localparam int unsigned DATA_W = 32;

  // Saturating count of discarded requests
  localparam int unsigned DROP_CNT_W = 16;

endpackage

// ==== verilog/route_pkg.sv ====
/*
 * Route header definitions
 * One 8-bit header word, read either as a unicast port index or as a
 * multicast port mask depending on its top bit
 */

package route_pkg;

  // Header word width
  localparam int unsigned HDR_W = 8;

  // Unicast port index width, wide enough for out-of-range codes
  localparam int unsigned IDX_W = 3;

  // Multicast mask has one bit per output port
  localparam int unsigned MASK_W = stream_cfg_pkg::N_PORTS;

  // Values of header bit 7
  localparam logic MODE_UNICAST   = 1'b0;
  localparam logic MODE_MULTICAST = 1'b1;

  // Unicast view
  typedef struct packed {
    logic                    mode;
    logic [HDR_W-2-IDX_W:0]  pad;
    logic [IDX_W-1:0]        idx;
  } route_uc_t;

  // Multicast view, bit i of mask selects port i
  typedef struct packed {
    logic                    mode;
    logic [HDR_W-2-MASK_W:0] pad;
    logic [MASK_W-1:0]       mask;
  } route_mc_t;

  // Both views overlay the same word and share the mode bit
  typedef union packed {
    route_uc_t uc;
    route_mc_t mc;
  } route_hdr_t;

endpackage

// ==== verilog/stream_fork.sv ====
/*
 * Static stream fork
 * Every output handshakes exactly once per input transfer, in any
 * order and any cycle; the input completes when the last one does
 */

`timescale 1ns/1ps

module stream_fork #(
  // Number of output streams
  parameter int unsigned N_OUP = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Input handshake
  input  logic             valid_i,
  output logic             ready_o,
  // Output handshakes
  output logic [N_OUP-1:0] valid_o,
  input  logic [N_OUP-1:0] ready_i
);

  // One flag per output that has already taken the current word
  logic [N_OUP-1:0] done_q;
  logic [N_OUP-1:0] done_d;
  logic [N_OUP-1:0] oup_hs;
  logic             inp_hs;

  // Offer the word only to outputs still owed it
  assign valid_o = {N_OUP{valid_i}} & ~done_q;

  // Output handshakes in this cycle
  assign oup_hs = valid_o & ready_i;

  // Done when every output has finished or finishes now
  assign ready_o = &(done_q | oup_hs);

  assign inp_hs = valid_i & ready_o;

  // Flag update
  always_comb begin
    if (inp_hs) begin
      // Word retired, start clean for the next one
      done_d = '0;
    end else begin
      done_d = done_q | oup_hs;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= '0;
    end else begin
      done_q <= done_d;
    end
  end

endmodule

// ==== verilog/stream_fork_dynamic.sv ====
/*
 * Dynamic stream fork
 * Wraps the static fork with a select mask so that each input word is
 * delivered only to the selected outputs
 */

`timescale 1ns/1ps

module stream_fork_dynamic #(
  // Number of output streams
  parameter int unsigned N_OUP = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Input handshake
  input  logic             valid_i,
  output logic             ready_o,
  // Select mask stream
  input  logic [N_OUP-1:0] sel_i,
  input  logic             sel_valid_i,
  output logic             sel_ready_o,
  // Output handshakes
  output logic [N_OUP-1:0] valid_o,
  input  logic [N_OUP-1:0] ready_i
);

  logic             fork_valid_in;
  logic             fork_ready_out;
  logic [N_OUP-1:0] fork_valid_out;
  logic [N_OUP-1:0] fork_ready_in;

  always_comb begin
    // Nothing moves until a mask is present
    fork_valid_in = 1'b0;
    fork_ready_in = '0;
    valid_o       = '0;
    ready_o       = 1'b0;
    if (sel_valid_i) begin
      fork_valid_in = valid_i;
      // Deselected outputs look ready so they finish at once
      fork_ready_in = ready_i | ~sel_i;
      valid_o       = fork_valid_out & sel_i;
      ready_o       = fork_ready_out;
    end
    // Mask and word retire together
    sel_ready_o = ready_o;
  end

  stream_fork #(
    .N_OUP   (N_OUP)
  ) u_fork (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (fork_valid_in),
    .ready_o (fork_ready_out),
    .valid_o (fork_valid_out),
    .ready_i (fork_ready_in)
  );

endmodule

// ==== verilog/out_slice.sv ====
/*
 * Output register slice
 * One-entry stage giving a sink a registered valid and data, refilled
 * in the same cycle its word leaves
 */

`timescale 1ns/1ps

module out_slice (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  input  logic [stream_cfg_pkg::DATA_W-1:0] in_data_i,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic [stream_cfg_pkg::DATA_W-1:0] out_data_o
);

  import stream_cfg_pkg::*;

  logic              valid_q;
  logic [DATA_W-1:0] data_q;

  // Free when empty or emptied now
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// ==== verilog/route_decode.sv ====
/*
 * Route decode stage
 * Turns the route header into a port select mask, discards requests
 * that have no destination and registers mask and payload for the fork
 */

`timescale 1ns/1ps

module route_decode (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Request stream
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  route_pkg::route_hdr_t               req_hdr_i,
  input  logic [stream_cfg_pkg::DATA_W-1:0]   req_data_i,
  // Decoded stream towards the fork
  output logic                                dec_valid_o,
  input  logic                                dec_ready_i,
  output logic [stream_cfg_pkg::N_PORTS-1:0]  dec_mask_o,
  output logic [stream_cfg_pkg::DATA_W-1:0]   dec_data_o,
  // Status
  output logic [stream_cfg_pkg::DROP_CNT_W-1:0] drop_count_o
);

  import stream_cfg_pkg::*;
  import route_pkg::*;

  logic [N_PORTS-1:0]    hdr_mask;
  logic                  hdr_drop;
  logic                  in_hs;

  // Stage register
  logic                  stage_valid_q;
  logic [N_PORTS-1:0]    stage_mask_q;
  logic [DATA_W-1:0]     stage_data_q;

  logic [DROP_CNT_W-1:0] drop_cnt_q;

  // Header decode
  always_comb begin
    case (req_hdr_i.uc.mode)
      // One-hot from index; indices past the last port shift out to zero
      MODE_UNICAST:   hdr_mask = {{(N_PORTS-1){1'b0}}, 1'b1} << req_hdr_i.uc.idx;
      MODE_MULTICAST: hdr_mask = req_hdr_i.mc.mask;
      default:        hdr_mask = '0;
    endcase
  end

  // Nothing to deliver
  assign hdr_drop = ~|hdr_mask;

  // Room when empty or draining this cycle
  assign req_ready_o = ~stage_valid_q | dec_ready_i;
  assign in_hs       = req_valid_i & req_ready_o;

  // Occupancy; a drop is consumed without filling the stage
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      stage_valid_q <= req_valid_i & ~hdr_drop;
    end
  end

  // Payload and mask
  always_ff @(posedge clk_i) begin
    if (in_hs && !hdr_drop) begin
      stage_mask_q <= hdr_mask;
      stage_data_q <= req_data_i;
    end
  end

  // Drop counter, holds at all ones
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      drop_cnt_q <= '0;
    end else if (in_hs && hdr_drop && (drop_cnt_q != '1)) begin
      drop_cnt_q <= drop_cnt_q + 1'b1;
    end
  end

  assign dec_valid_o  = stage_valid_q;
  assign dec_mask_o   = stage_mask_q;
  assign dec_data_o   = stage_data_q;
  assign drop_count_o = drop_cnt_q;

endmodule

// ==== verilog/mcast_top.sv ====
/*
 * Multicast packet dispatcher
 * Decode stage, dynamic fork and one register slice per output port;
 * each request goes to the port or ports its route header names
 */

`timescale 1ns/1ps

module mcast_top (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  // Request stream
  input  logic                                              req_valid_i,
  output logic                                              req_ready_o,
  input  route_pkg::route_hdr_t                             req_hdr_i,
  input  logic [stream_cfg_pkg::DATA_W-1:0]                 req_data_i,
  // Per-port output streams
  output logic [stream_cfg_pkg::N_PORTS-1:0]                out_valid_o,
  input  logic [stream_cfg_pkg::N_PORTS-1:0]                out_ready_i,
  output logic [stream_cfg_pkg::N_PORTS-1:0]
               [stream_cfg_pkg::DATA_W-1:0]                 out_data_o,
  // Discarded request count
  output logic [stream_cfg_pkg::DROP_CNT_W-1:0]             drop_count_o
);

  import stream_cfg_pkg::*;
  import route_pkg::*;

  // Decode to fork
  logic               dec_valid;
  logic               dec_ready;
  logic [N_PORTS-1:0] dec_mask;
  logic [DATA_W-1:0]  dec_data;

  // Fork to slices
  logic [N_PORTS-1:0] fork_valid;
  logic [N_PORTS-1:0] fork_ready;

  route_decode u_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_hdr_i    (req_hdr_i),
    .req_data_i   (req_data_i),
    .dec_valid_o  (dec_valid),
    .dec_ready_i  (dec_ready),
    .dec_mask_o   (dec_mask),
    .dec_data_o   (dec_data),
    .drop_count_o (drop_count_o)
  );

  // Mask travels with the word, so one valid drives both handshakes
  stream_fork_dynamic #(
    .N_OUP       (N_PORTS)
  ) u_fork (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (dec_valid),
    .ready_o     (dec_ready),
    .sel_i       (dec_mask),
    .sel_valid_i (dec_valid),
    .sel_ready_o (),
    .valid_o     (fork_valid),
    .ready_i     (fork_ready)
  );

  // Payload is held in decode until every selected port has it
  for (genvar i = 0; i < N_PORTS; i++) begin : gen_port
    out_slice u_slice (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (fork_valid[i]),
      .in_ready_o  (fork_ready[i]),
      .in_data_i   (dec_data),
      .out_valid_o (out_valid_o[i]),
      .out_ready_i (out_ready_i[i]),
      .out_data_o  (out_data_o[i])
    );
  end

endmodule

// ==== tests/mcast_chk.sv ====
/*
 * Handshake checker for the multicast dispatcher
 * Valid hold, output data stability and idle outputs during reset
 */

`timescale 1ns/1ps

module mcast_chk (
  input logic                                                   clk_i,
  input logic                                                   rst_n_i,
  input logic                                                   req_valid_i,
  input logic                                                   req_ready_o,
  input logic [stream_cfg_pkg::N_PORTS-1:0]                     out_valid_o,
  input logic [stream_cfg_pkg::N_PORTS-1:0]                     out_ready_i,
  input logic [stream_cfg_pkg::N_PORTS-1:0][stream_cfg_pkg::DATA_W-1:0] out_data_o
);

  import stream_cfg_pkg::*;

  // Request valid may only fall after a transfer
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_o |=> req_valid_i)
    else $error("req_valid_i dropped before its handshake");

  for (genvar i = 0; i < N_PORTS; i++) begin : gen_port
    // Stalled output keeps valid and its word
    a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o[i] && !out_ready_i[i] |=> out_valid_o[i] && $stable(out_data_o[i]))
      else $error("Output %0d changed while stalled", i);
  end

  // Nothing offered while in reset
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |-> out_valid_o == '0)
    else $error("Output valid high during reset");

endmodule

// ==== tests/mcast_tb.sv ====
/*
 * Testbench for the multicast dispatcher
 * Replays requests from a vector file, drives random sinks and keeps
 * a per-port scoreboard of payloads and latencies
 */

`timescale 1ns/1ps

module mcast_tb;

  import stream_cfg_pkg::*;
  import route_pkg::*;

  localparam int MAX_VEC = 64;

  logic                           clk;
  logic                           rst_n;
  logic                           req_valid;
  logic                           req_ready;
  route_hdr_t                     req_hdr;
  logic [DATA_W-1:0]              req_data;
  logic [N_PORTS-1:0]             out_valid;
  logic [N_PORTS-1:0]             out_ready;
  logic [N_PORTS-1:0][DATA_W-1:0] out_data;
  logic [DROP_CNT_W-1:0]          drop_count;

  // Requests as read from the file
  route_hdr_t         vec_hdr  [MAX_VEC];
  logic [DATA_W-1:0]  vec_data [MAX_VEC];
  logic [N_PORTS-1:0] vec_mask [MAX_VEC];
  int                 n_vec;
  int                 exp_drops;
  bit                 vec_loaded;

  // Expected payloads per port, with handshake cycle or -1 if untimed
  logic [DATA_W-1:0]  exp_q     [N_PORTS][$];
  int                 exp_cyc_q [N_PORTS][$];

  logic [N_PORTS-1:0] cur_mask;
  bit                 timed_phase;
  bit                 sinks_random;
  int                 cycle_cnt;
  int                 seed;
  logic [31:0]        rnd;

  mcast_top uut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_hdr_i    (req_hdr),
    .req_data_i   (req_data),
    .out_valid_o  (out_valid),
    .out_ready_i  (out_ready),
    .out_data_o   (out_data),
    .drop_count_o (drop_count)
  );

  bind mcast_top mcast_chk u_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp_val,
                            input logic [DATA_W-1:0] act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp_val, act_val));
    end
  endtask

  task automatic check_count(input string name, input logic [DROP_CNT_W-1:0] exp_val,
                             input logic [DROP_CNT_W-1:0] act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp_val, act_val));
    end
  endtask

  task automatic check_mask(input string name, input logic [N_PORTS-1:0] exp_val,
                            input logic [N_PORTS-1:0] act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp_val, act_val));
    end
  endtask

  task automatic check_latency(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp_val, act_val));
    end
  endtask

  task automatic check_ready(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp_val, act_val));
    end
  endtask

  // Ports a header should reach, zero when nothing is deliverable
  function automatic logic [N_PORTS-1:0] expected_mask(input route_hdr_t hdr);
    logic [N_PORTS-1:0] mask;
    mask = '0;
    if (hdr.uc.mode == MODE_MULTICAST) begin
      mask = hdr.mc.mask;
    end else if (int'(hdr.uc.idx) < int'(N_PORTS)) begin
      mask = N_PORTS'(1) << hdr.uc.idx;
    end
    return mask;
  endfunction

  task automatic load_vectors();
    int                 fd;
    int                 got;
    string              line;
    logic [HDR_W-1:0]   hdr;
    logic [DATA_W-1:0]  data;
    logic [N_PORTS-1:0] mask;
    n_vec     = 0;
    exp_drops = 0;
    fd = $fopen("tests/mcast_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the vector file tests/mcast_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      got  = $fgets(line, fd);
      // Comment lines do not parse as three hex fields
      if (got > 0 && $sscanf(line, "%h %h %h", hdr, data, mask) == 3) begin
        if (n_vec == MAX_VEC) begin
          abort_run("Vector file holds more requests than the testbench can store");
        end
        vec_hdr[n_vec]  = hdr;
        vec_data[n_vec] = data;
        vec_mask[n_vec] = mask;
        if (mask == '0) exp_drops++;
        n_vec++;
      end
    end
    $fclose(fd);
    if (n_vec == 0) begin
      abort_run("Vector file holds no requests");
    end
    vec_loaded = 1'b1;
  endtask

  // Called on a rising edge, returns on the edge of the handshake
  task automatic send_request(input int idx);
    check_mask($sformatf("vector%0d_mask", idx), expected_mask(vec_hdr[idx]), vec_mask[idx]);
    req_valid <= 1'b1;
    req_hdr   <= vec_hdr[idx];
    req_data  <= vec_data[idx];
    cur_mask  <= vec_mask[idx];
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
  endtask

  // Stop sending and wait until every port has emptied its queue
  task automatic wait_drain();
    int pending;
    req_valid <= 1'b0;
    do begin
      @(posedge clk);
      pending = 0;
      for (int p = 0; p < N_PORTS; p++) pending += exp_q[p].size();
    end while (pending != 0);
    repeat (4) @(posedge clk);
  endtask

  task automatic score_output(input int port);
    logic [DATA_W-1:0] exp_data;
    int                hs_cycle;
    if (exp_q[port].size() == 0) begin
      abort_run($sformatf("Port %0d delivered %h although no request was sent there",
                          port, out_data[port]));
    end
    exp_data = exp_q[port].pop_front();
    hs_cycle = exp_cyc_q[port].pop_front();
    check_data($sformatf("port%0d_payload", port), exp_data, out_data[port]);
    if (hs_cycle >= 0) begin
      check_latency($sformatf("port%0d_latency", port), 2, cycle_cnt - hs_cycle);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Sinks stay ready in the timed phase, then stall at random
  always @(posedge clk) begin
    if (sinks_random) begin
      rnd = $random(seed);
      out_ready <= rnd[N_PORTS-1:0];
    end else begin
      out_ready <= '1;
    end
  end

  // Handshakes are sampled half a cycle before the edge that takes them
  always @(negedge clk) begin
    if (rst_n) begin
      // All sinks ready, so the decode register drains every cycle
      if (timed_phase) begin
        check_ready("req_ready", 1'b1, req_ready);
      end
      if (req_valid && req_ready) begin
        for (int p = 0; p < N_PORTS; p++) begin
          if (cur_mask[p]) begin
            exp_q[p].push_back(req_data);
            exp_cyc_q[p].push_back(timed_phase ? cycle_cnt : -1);
          end
        end
      end
      for (int p = 0; p < N_PORTS; p++) begin
        if (out_valid[p] && out_ready[p]) score_output(p);
      end
    end
  end

  // Budget of 40 cycles per request plus reset and drain
  initial begin
    wait (vec_loaded);
    repeat (n_vec * 40 + 200) @(posedge clk);
    abort_run($sformatf("Timeout: requests still undelivered after %0d cycles",
                        n_vec * 40 + 200));
  end

  initial begin
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_hdr      = '0;
    req_data     = '0;
    out_ready    = '1;
    cur_mask     = '0;
    timed_phase  = 1'b1;
    sinks_random = 1'b0;
    cycle_cnt    = 0;
    seed         = 32'he0358232;
    load_vectors();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < n_vec; i++) begin
      // Second half runs under random back-pressure
      if (i == n_vec / 2) begin
        wait_drain();
        timed_phase  <= 1'b0;
        sinks_random <= 1'b1;
      end
      send_request(i);
    end
    wait_drain();
    check_count("drop_count", DROP_CNT_W'(exp_drops), drop_count);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== project.f ====
verilog/stream_cfg_pkg.sv
verilog/route_pkg.sv
verilog/stream_fork.sv
verilog/stream_fork_dynamic.sv
verilog/out_slice.sv
verilog/route_decode.sv
verilog/mcast_top.sv
tests/mcast_chk.sv
tests/mcast_tb.sv

// ==== Makefile ====
# Verilator simulation of the multicast dispatcher
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mcast_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/mcast_vectors.txt ====
// header payload expected_mask, all hex, one request per line
// expected_mask 0 means the request is dropped; second half runs with back-pressure
00 a0000001 1
01 a0000002 2
02 a0000003 4
03 a0000004 8
04 a0000005 0
8f a0000006 f
85 a0000007 5
80 a0000008 0
7a a0000009 4
f3 a000000a 3
07 a000000b 0
8a a000000c a
81 a000000d 1
88 a000000e 8
06 a000000f 0
8f a0000010 f
03 a0000011 8
8c a0000012 c
00 a0000013 1
86 a0000014 6
d0 a0000015 0
8f a0000016 f
02 a0000017 4
89 a0000018 9
8f a0000019 f
01 a000001a 2
